//--- logic/ao_config.svh
// always-on subsystem constants
// widths, counts and register map of the three register blocks
`ifndef AO_CONFIG_SVH
`define AO_CONFIG_SVH

`define AO_NUM_GPIO       8
`define AO_NUM_BANKS      2
// domain 0 is cpu, 1 is peripheral, 2 and up are memory banks
`define AO_NUM_DOMAINS    4
`define AO_NUM_EXT_FAST   2
// gpio interrupts in the low bits, external lines above them
`define AO_NUM_FAST_INTR  10
`define AO_ADDR_W         8
`define AO_DATA_W         32

// block 0, power manager
`define AO_PWR_OFF_REQ    8'h00
`define AO_PWR_STATUS     8'h04
`define AO_BANK_RETENTIVE 8'h08
// block 1, gpio
`define AO_GPIO_OUT         8'h40
`define AO_GPIO_OE          8'h44
`define AO_GPIO_IN          8'h48
`define AO_GPIO_INTR_EN     8'h4C
`define AO_GPIO_INTR_STATUS 8'h50
// block 2, fast interrupts
`define AO_FAST_PENDING   8'h80
`define AO_FAST_ENABLE    8'h84

`endif

//--- logic/ao_bus_pkg.sv
// register bus types for the always-on subsystem
// level valid strobe, response in the same cycle

`include "ao_config.svh"

package ao_bus_pkg;

  typedef struct packed {
    logic [1:0] block;
    logic [3:0] word;
    logic [1:0] byte_off;
  } reg_addr_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    reg_addr_t             addr;
    logic [`AO_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`AO_DATA_W-1:0] rdata;
    logic                  error;
  } reg_rsp_t;

endpackage

//--- logic/ao_power_pkg.sv
// power control types
// pad-side control of one domain and the sequencer states

package ao_power_pkg;

  // all fields active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
  } pwr_ctrl_out_t;

  typedef enum logic [3:0] {
    ON,
    GATE_CLK,
    ISOLATE,
    HOLD_RST,
    SWITCH_OFF,
    OFF,
    SWITCH_ON,
    RELEASE_RST,
    RELEASE_ISO
  } pwr_seq_state_t;

endpackage

//--- logic/power_domain_seq.sv
`timescale 1ns/1ns
// power sequencer for one domain
// gates clock, isolates, resets and switches off, then undoes it in reverse

module power_domain_seq (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        off_req_i,
  input  logic                        ack_n_i,
  output ao_power_pkg::pwr_ctrl_out_t ctrl_o,
  output logic                        is_on_o
);

  ao_power_pkg::pwr_seq_state_t state_q;
  ao_power_pkg::pwr_seq_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ao_power_pkg::ON: begin
        if (off_req_i) begin
          state_d = ao_power_pkg::GATE_CLK;
        end
      end
      ao_power_pkg::GATE_CLK:    state_d = ao_power_pkg::ISOLATE;
      ao_power_pkg::ISOLATE:     state_d = ao_power_pkg::HOLD_RST;
      ao_power_pkg::HOLD_RST:    state_d = ao_power_pkg::SWITCH_OFF;
      ao_power_pkg::SWITCH_OFF: begin
        // switch cell reports off
        if (!ack_n_i) begin
          state_d = ao_power_pkg::OFF;
        end
      end
      ao_power_pkg::OFF: begin
        if (!off_req_i) begin
          state_d = ao_power_pkg::SWITCH_ON;
        end
      end
      ao_power_pkg::SWITCH_ON: begin
        if (ack_n_i) begin
          state_d = ao_power_pkg::RELEASE_RST;
        end
      end
      ao_power_pkg::RELEASE_RST: state_d = ao_power_pkg::RELEASE_ISO;
      ao_power_pkg::RELEASE_ISO: state_d = ao_power_pkg::ON;
      default:                   state_d = ao_power_pkg::ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ao_power_pkg::ON;
    end else begin
      state_q <= state_d;
    end
  end

  // clock runs only when fully on
  assign ctrl_o.clkgate_en_n = (state_q == ao_power_pkg::ON);
  assign ctrl_o.isogate_en_n = state_q inside {ao_power_pkg::ON, ao_power_pkg::GATE_CLK,
                                               ao_power_pkg::RELEASE_ISO};
  assign ctrl_o.rst_n        = state_q inside {ao_power_pkg::ON, ao_power_pkg::GATE_CLK,
                                               ao_power_pkg::ISOLATE, ao_power_pkg::RELEASE_RST,
                                               ao_power_pkg::RELEASE_ISO};
  assign ctrl_o.pwrgate_en_n = !(state_q inside {ao_power_pkg::SWITCH_OFF, ao_power_pkg::OFF});
  assign is_on_o             = (state_q == ao_power_pkg::ON);

endmodule

//--- logic/power_manager.sv
`timescale 1ns/1ns
// power manager, off requests and bank retention registers
// one sequencer per domain, cpu domain woken by the fast interrupt

`include "ao_config.svh"

module power_manager (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  ao_bus_pkg::reg_req_t                                req_i,
  output ao_bus_pkg::reg_rsp_t                                rsp_o,
  input  logic                                                core_sleep_i,
  input  logic                                                wake_i,
  input  logic [`AO_NUM_DOMAINS-1:0]                          pwrgate_ack_ni,
  output ao_power_pkg::pwr_ctrl_out_t [`AO_NUM_DOMAINS-1:0]   pwr_ctrl_o,
  output logic [`AO_NUM_BANKS-1:0]                            bank_retentive_no
);

  logic [`AO_ADDR_W-1:0]      word_addr;
  logic                       hit;
  logic                       wr_en;
  logic [`AO_NUM_DOMAINS-1:0] off_req_q;
  logic [`AO_NUM_DOMAINS-1:0] dom_off_req;
  logic [`AO_NUM_DOMAINS-1:0] dom_on;
  logic [`AO_NUM_BANKS-1:0]   retentive_q;

  assign word_addr = {req_i.addr.block, req_i.addr.word, 2'b00};
  assign wr_en     = req_i.valid && req_i.write;

  always_comb begin
    rsp_o.rdata = '0;
    hit         = 1'b1;
    case (word_addr)
      `AO_PWR_OFF_REQ:    rsp_o.rdata[`AO_NUM_DOMAINS-1:0] = off_req_q;
      `AO_PWR_STATUS:     rsp_o.rdata[`AO_NUM_DOMAINS-1:0] = dom_on;
      `AO_BANK_RETENTIVE: rsp_o.rdata[`AO_NUM_BANKS-1:0]   = retentive_q;
      default:            hit = 1'b0;
    endcase
    rsp_o.error = !hit;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      off_req_q   <= '0;
      retentive_q <= '0;
    end else if (wr_en) begin
      if (word_addr == `AO_PWR_OFF_REQ) begin
        off_req_q <= req_i.wdata[`AO_NUM_DOMAINS-1:0];
      end
      if (word_addr == `AO_BANK_RETENTIVE) begin
        retentive_q <= req_i.wdata[`AO_NUM_BANKS-1:0];
      end
    end
  end

  // cpu goes down only while the core sleeps and nothing is pending
  always_comb begin
    dom_off_req    = off_req_q;
    dom_off_req[0] = off_req_q[0] & core_sleep_i & ~wake_i;
  end

  for (genvar d = 0; d < `AO_NUM_DOMAINS; d++) begin : g_domain
    power_domain_seq power_domain_seq_i (
      .clk_i,
      .rst_n_i,
      .off_req_i(dom_off_req[d]),
      .ack_n_i  (pwrgate_ack_ni[d]),
      .ctrl_o   (pwr_ctrl_o[d]),
      .is_on_o  (dom_on[d])
    );
  end

  assign bank_retentive_no = ~retentive_q;

endmodule

//--- logic/gpio_ao.sv
`timescale 1ns/1ns
// always-on gpio, output and enable registers
// two-flop input sync and rising edge interrupts with write-1 clear

`include "ao_config.svh"

module gpio_ao (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ao_bus_pkg::reg_req_t     req_i,
  output ao_bus_pkg::reg_rsp_t     rsp_o,
  input  logic [`AO_NUM_GPIO-1:0]  gpio_i,
  output logic [`AO_NUM_GPIO-1:0]  gpio_o,
  output logic [`AO_NUM_GPIO-1:0]  gpio_oe_o,
  output logic [`AO_NUM_GPIO-1:0]  intr_o
);

  logic [`AO_ADDR_W-1:0]   word_addr;
  logic                    hit;
  logic                    wr_en;
  logic [`AO_NUM_GPIO-1:0] out_q;
  logic [`AO_NUM_GPIO-1:0] oe_q;
  logic [`AO_NUM_GPIO-1:0] intr_en_q;
  logic [`AO_NUM_GPIO-1:0] status_q;
  logic [`AO_NUM_GPIO-1:0] sync1_q;
  logic [`AO_NUM_GPIO-1:0] sync2_q;
  logic [`AO_NUM_GPIO-1:0] prev_q;
  logic [`AO_NUM_GPIO-1:0] status_clr;
  logic [`AO_NUM_GPIO-1:0] rise;

  assign word_addr = {req_i.addr.block, req_i.addr.word, 2'b00};
  assign wr_en     = req_i.valid && req_i.write;

  always_comb begin
    rsp_o.rdata = '0;
    hit         = 1'b1;
    case (word_addr)
      `AO_GPIO_OUT:         rsp_o.rdata[`AO_NUM_GPIO-1:0] = out_q;
      `AO_GPIO_OE:          rsp_o.rdata[`AO_NUM_GPIO-1:0] = oe_q;
      `AO_GPIO_IN:          rsp_o.rdata[`AO_NUM_GPIO-1:0] = sync2_q;
      `AO_GPIO_INTR_EN:     rsp_o.rdata[`AO_NUM_GPIO-1:0] = intr_en_q;
      `AO_GPIO_INTR_STATUS: rsp_o.rdata[`AO_NUM_GPIO-1:0] = status_q;
      default:              hit = 1'b0;
    endcase
    rsp_o.error = !hit;
  end

  assign rise       = sync2_q & ~prev_q & intr_en_q;
  assign status_clr = (wr_en && word_addr == `AO_GPIO_INTR_STATUS) ?
                      req_i.wdata[`AO_NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      // a new edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | rise;
      if (wr_en && word_addr == `AO_GPIO_OUT) begin
        out_q <= req_i.wdata[`AO_NUM_GPIO-1:0];
      end
      if (wr_en && word_addr == `AO_GPIO_OE) begin
        oe_q <= req_i.wdata[`AO_NUM_GPIO-1:0];
      end
      if (wr_en && word_addr == `AO_GPIO_INTR_EN) begin
        intr_en_q <= req_i.wdata[`AO_NUM_GPIO-1:0];
      end
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = status_q;

endmodule

//--- logic/fast_intr_ctrl.sv
`timescale 1ns/1ns
// fast interrupt controller
// level sources set pending bits, enabled pending bits raise irq

`include "ao_config.svh"

module fast_intr_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  ao_bus_pkg::reg_req_t         req_i,
  output ao_bus_pkg::reg_rsp_t         rsp_o,
  input  logic [`AO_NUM_FAST_INTR-1:0] src_i,
  output logic                         irq_o
);

  logic [`AO_ADDR_W-1:0]        word_addr;
  logic                         hit;
  logic                         wr_en;
  logic [`AO_NUM_FAST_INTR-1:0] pending_q;
  logic [`AO_NUM_FAST_INTR-1:0] enable_q;
  logic [`AO_NUM_FAST_INTR-1:0] pending_clr;

  assign word_addr = {req_i.addr.block, req_i.addr.word, 2'b00};
  assign wr_en     = req_i.valid && req_i.write;

  always_comb begin
    rsp_o.rdata = '0;
    hit         = 1'b1;
    case (word_addr)
      `AO_FAST_PENDING: rsp_o.rdata[`AO_NUM_FAST_INTR-1:0] = pending_q;
      `AO_FAST_ENABLE:  rsp_o.rdata[`AO_NUM_FAST_INTR-1:0] = enable_q;
      default:          hit = 1'b0;
    endcase
    rsp_o.error = !hit;
  end

  assign pending_clr = (wr_en && word_addr == `AO_FAST_PENDING) ?
                       req_i.wdata[`AO_NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // a source still high sets its bit again
      pending_q <= (pending_q & ~pending_clr) | src_i;
      if (wr_en && word_addr == `AO_FAST_ENABLE) begin
        enable_q <= req_i.wdata[`AO_NUM_FAST_INTR-1:0];
      end
    end
  end

  assign irq_o = |(pending_q & enable_q);

endmodule

//--- logic/ao_reg_demux.sv
`timescale 1ns/1ns
// register bus demux for the always-on blocks
// block select steers valid, unmapped block answers with error

module ao_reg_demux (
  input  ao_bus_pkg::reg_req_t req_i,
  output ao_bus_pkg::reg_rsp_t rsp_o,
  output ao_bus_pkg::reg_req_t pwr_req_o,
  output ao_bus_pkg::reg_req_t gpio_req_o,
  output ao_bus_pkg::reg_req_t intr_req_o,
  input  ao_bus_pkg::reg_rsp_t pwr_rsp_i,
  input  ao_bus_pkg::reg_rsp_t gpio_rsp_i,
  input  ao_bus_pkg::reg_rsp_t intr_rsp_i
);

  always_comb begin
    pwr_req_o        = req_i;
    gpio_req_o       = req_i;
    intr_req_o       = req_i;
    pwr_req_o.valid  = req_i.valid && (req_i.addr.block == 2'd0);
    gpio_req_o.valid = req_i.valid && (req_i.addr.block == 2'd1);
    intr_req_o.valid = req_i.valid && (req_i.addr.block == 2'd2);
  end

  always_comb begin
    case (req_i.addr.block)
      2'd0: rsp_o = pwr_rsp_i;
      2'd1: rsp_o = gpio_rsp_i;
      2'd2: rsp_o = intr_rsp_i;
      default: begin
        // nothing mapped in block 3
        rsp_o.rdata = '0;
        rsp_o.error = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/ao_subsystem.sv
`timescale 1ns/1ns
// always-on subsystem top level
// register demux, power manager, gpio and fast interrupt controller

`include "ao_config.svh"

module ao_subsystem (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  ao_bus_pkg::reg_req_t                              reg_req_i,
  output ao_bus_pkg::reg_rsp_t                              reg_rsp_o,
  input  logic [`AO_NUM_GPIO-1:0]                           gpio_i,
  output logic [`AO_NUM_GPIO-1:0]                           gpio_o,
  output logic [`AO_NUM_GPIO-1:0]                           gpio_oe_o,
  input  logic [`AO_NUM_EXT_FAST-1:0]                       ext_fast_intr_i,
  input  logic                                              core_sleep_i,
  output logic                                              irq_o,
  input  logic [`AO_NUM_DOMAINS-1:0]                        pwrgate_ack_ni,
  output ao_power_pkg::pwr_ctrl_out_t [`AO_NUM_DOMAINS-1:0] pwr_ctrl_o,
  output logic [`AO_NUM_BANKS-1:0]                          bank_retentive_no
);

  ao_bus_pkg::reg_req_t         pwr_req;
  ao_bus_pkg::reg_rsp_t         pwr_rsp;
  ao_bus_pkg::reg_req_t         gpio_req;
  ao_bus_pkg::reg_rsp_t         gpio_rsp;
  ao_bus_pkg::reg_req_t         intr_req;
  ao_bus_pkg::reg_rsp_t         intr_rsp;
  logic [`AO_NUM_GPIO-1:0]      gpio_intr;
  logic [`AO_NUM_FAST_INTR-1:0] fast_src;

  // external lines above the gpio interrupts
  assign fast_src = {ext_fast_intr_i, gpio_intr};

  ao_reg_demux ao_reg_demux_i (
    .req_i     (reg_req_i),
    .rsp_o     (reg_rsp_o),
    .pwr_req_o (pwr_req),
    .gpio_req_o(gpio_req),
    .intr_req_o(intr_req),
    .pwr_rsp_i (pwr_rsp),
    .gpio_rsp_i(gpio_rsp),
    .intr_rsp_i(intr_rsp)
  );

  power_manager power_manager_i (
    .clk_i,
    .rst_n_i,
    .req_i            (pwr_req),
    .rsp_o            (pwr_rsp),
    .core_sleep_i,
    .wake_i           (irq_o),
    .pwrgate_ack_ni,
    .pwr_ctrl_o,
    .bank_retentive_no
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .req_i    (gpio_req),
    .rsp_o    (gpio_rsp),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o   (gpio_intr)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .req_i(intr_req),
    .rsp_o(intr_rsp),
    .src_i(fast_src),
    .irq_o
  );

endmodule

//--- test/tb_ao_subsystem.sv
`timescale 1ns/1ns
// testbench for the always-on subsystem
// directed register, gpio, interrupt and power sequence tests with a switch ack model

`include "ao_config.svh"

module tb_ao_subsystem;

  // about 70 bus accesses of 2 cycles plus five power sequences with up to 8 ack
  // cycles each stay below 600 cycles
  localparam int CYCLE_LIMIT = 5000;
  localparam int WAIT_LIMIT  = 40;
  // bit positions of the fields in a pwr_ctrl_out_t word
  localparam logic [1:0] CLK_BIT = 2'd0;
  localparam logic [1:0] RST_BIT = 2'd1;
  localparam logic [1:0] ISO_BIT = 2'd2;
  localparam logic [1:0] PWR_BIT = 2'd3;

  logic                                              clk;
  logic                                              rst_n;
  ao_bus_pkg::reg_req_t                              req;
  ao_bus_pkg::reg_rsp_t                              rsp;
  logic [`AO_NUM_GPIO-1:0]                           gpio_in;
  logic [`AO_NUM_GPIO-1:0]                           gpio_out;
  logic [`AO_NUM_GPIO-1:0]                           gpio_oe;
  logic [`AO_NUM_EXT_FAST-1:0]                       ext_fast;
  logic                                              core_sleep;
  logic                                              irq;
  logic [`AO_NUM_DOMAINS-1:0]                        ack_n;
  ao_power_pkg::pwr_ctrl_out_t [`AO_NUM_DOMAINS-1:0] pwr_ctrl;
  logic [`AO_NUM_BANKS-1:0]                          bank_ret_n;

  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] rng;
  int          ack_wait [`AO_NUM_DOMAINS];

  ao_subsystem DUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .reg_req_i        (req),
    .reg_rsp_o        (rsp),
    .gpio_i           (gpio_in),
    .gpio_o           (gpio_out),
    .gpio_oe_o        (gpio_oe),
    .ext_fast_intr_i  (ext_fast),
    .core_sleep_i     (core_sleep),
    .irq_o            (irq),
    .pwrgate_ack_ni   (ack_n),
    .pwr_ctrl_o       (pwr_ctrl),
    .bank_retentive_no(bank_ret_n)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run passed %0d cycles, %0d errors so far", CYCLE_LIMIT, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // switch cells answer each pwrgate_en_n change after 1 to 8 cycles
  always @(negedge clk) begin
    if (rst_n) begin
      for (int d = 0; d < `AO_NUM_DOMAINS; d++) begin
        if (ack_wait[d] != 0) begin
          ack_wait[d]--;
          if (ack_wait[d] == 0) begin
            ack_n[d] = pwr_ctrl[d].pwrgate_en_n;
          end
        end else if (ack_n[d] !== pwr_ctrl[d].pwrgate_en_n) begin
          rng         = xorshift32(rng);
          ack_wait[d] = 1 + int'(rng[2:0]);
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic bus_access(input logic wr, input logic [7:0] offset, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    req.valid = 1'b1;
    req.write = wr;
    req.addr  = ao_bus_pkg::reg_addr_t'(offset);
    req.wdata = wdata;
    #1;
    rdata = rsp.rdata;
    err   = rsp.error;
    @(negedge clk);
    req.valid = 1'b0;
  endtask

  task automatic write_reg(input string name, input logic [7:0] offset, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, offset, wdata, rdata, err);
    check_value({name, " write error"}, 32'd0, {31'd0, err});
  endtask

  task automatic check_read(input string name, input logic [7:0] offset, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, offset, 32'd0, rdata, err);
    check_value(name, exp, rdata);
    check_value({name, " read error"}, 32'd0, {31'd0, err});
  endtask

  task automatic expect_error(input string name, input logic wr, input logic [7:0] offset);
    logic [31:0] rdata;
    logic        err;
    bus_access(wr, offset, 32'hffff_ffff, rdata, err);
    check_value({name, " error"}, 32'd1, {31'd0, err});
    check_value({name, " rdata"}, 32'd0, rdata);
  endtask

  task automatic poll_status(input string name, input logic [3:0] exp);
    logic [31:0] rdata;
    logic        err;
    int          n;
    n     = 0;
    rdata = '0;
    while (rdata[3:0] !== exp && n < WAIT_LIMIT) begin
      bus_access(1'b0, `AO_PWR_STATUS, 32'd0, rdata, err);
      n++;
    end
    check_value({name, " PWR_STATUS"}, {28'd0, exp}, rdata);
  endtask

  task automatic wait_irq(input string name, input logic level);
    int n;
    n = 0;
    while (irq !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    checks++;
    assert (irq === level) else begin
      errors++;
      $display("%s: irq_o did not reach %0b within %0d cycles", name, level, WAIT_LIMIT);
    end
  endtask

  task automatic wait_domain_off(input string name, input int dom);
    int n;
    n = 0;
    while ((pwr_ctrl[dom] !== 4'h0 || ack_n[dom] !== 1'b0) && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    checks++;
    assert (pwr_ctrl[dom] === 4'h0 && ack_n[dom] === 1'b0) else begin
      errors++;
      $display("%s: domain %0d did not switch off within %0d cycles", name, dom, WAIT_LIMIT);
    end
  endtask

  // each step flips one field, in the order given from the low bits of order
  task automatic follow_sequence(input string name, input int dom, input logic [7:0] order);
    logic [3:0] prev;
    logic [3:0] cur;
    logic [3:0] exp;
    logic [1:0] idx;
    int         step;
    int         n;
    prev = pwr_ctrl[dom];
    step = 0;
    n    = 0;
    while (step < 4 && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
      cur = pwr_ctrl[dom];
      for (int o = 0; o < `AO_NUM_DOMAINS; o++) begin
        if (o != dom) begin
          check_value($sformatf("%s domain %0d", name, o), 32'hF, {28'd0, pwr_ctrl[o]});
        end
      end
      if (cur !== prev) begin
        idx      = order[2*step +: 2];
        exp      = prev;
        exp[idx] = ~prev[idx];
        check_value($sformatf("%s step %0d", name, step), {28'd0, exp}, {28'd0, cur});
        prev = cur;
        step++;
      end
    end
    checks++;
    assert (step == 4) else begin
      errors++;
      $display("%s: sequence stopped after %0d of 4 steps", name, step);
    end
  endtask

  task automatic reset_state();
    check_read("reset PWR_STATUS", `AO_PWR_STATUS, 32'hF);
    for (int d = 0; d < `AO_NUM_DOMAINS; d++) begin
      check_value($sformatf("reset pwr_ctrl %0d", d), 32'hF, {28'd0, pwr_ctrl[d]});
    end
    check_value("reset bank_retentive_no", 32'h3, {30'd0, bank_ret_n});
    check_value("reset gpio_oe_o", 32'h0, {24'd0, gpio_oe});
    check_value("reset irq_o", 32'h0, {31'd0, irq});
  endtask

  task automatic gpio_registers();
    write_reg("gpio out", `AO_GPIO_OUT, 32'hA5);
    write_reg("gpio oe", `AO_GPIO_OE, 32'h3C);
    check_read("gpio out readback", `AO_GPIO_OUT, 32'hA5);
    check_read("gpio oe readback", `AO_GPIO_OE, 32'h3C);
    check_value("gpio_o pins", 32'hA5, {24'd0, gpio_out});
    check_value("gpio_oe_o pins", 32'h3C, {24'd0, gpio_oe});
    @(negedge clk);
    gpio_in = 8'h5A;
    repeat (3) @(negedge clk);
    check_read("gpio in", `AO_GPIO_IN, 32'h5A);
    gpio_in = 8'h00;
    repeat (4) @(negedge clk);
  endtask

  task automatic gpio_interrupts();
    write_reg("gpio intr en", `AO_GPIO_INTR_EN, 32'h04);
    // pin 5 enabled here so a stray status bit would reach irq_o
    write_reg("fast enable", `AO_FAST_ENABLE, 32'h024);
    @(negedge clk);
    gpio_in = 8'h04;
    wait_irq("gpio edge", 1'b1);
    check_read("gpio intr status", `AO_GPIO_INTR_STATUS, 32'h04);
    check_read("fast pending", `AO_FAST_PENDING, 32'h004);
    write_reg("gpio status clear", `AO_GPIO_INTR_STATUS, 32'h04);
    write_reg("fast pending clear", `AO_FAST_PENDING, 32'h004);
    check_value("irq_o after clear", 32'h0, {31'd0, irq});
    check_read("gpio status cleared", `AO_GPIO_INTR_STATUS, 32'h0);
    check_read("fast pending cleared", `AO_FAST_PENDING, 32'h0);
    // pin 5 edge with its enable off
    @(negedge clk);
    gpio_in = 8'h24;
    repeat (6) @(negedge clk);
    check_read("disabled pin status", `AO_GPIO_INTR_STATUS, 32'h0);
    check_read("disabled pin pending", `AO_FAST_PENDING, 32'h0);
    check_value("disabled pin irq_o", 32'h0, {31'd0, irq});
    gpio_in = 8'h00;
    repeat (4) @(negedge clk);
  endtask

  task automatic peripheral_sequence();
    write_reg("peripheral off request", `AO_PWR_OFF_REQ, 32'h2);
    follow_sequence("peripheral down", 1, {PWR_BIT, RST_BIT, ISO_BIT, CLK_BIT});
    wait_domain_off("peripheral down", 1);
    check_read("peripheral off PWR_STATUS", `AO_PWR_STATUS, 32'hD);
    write_reg("peripheral on request", `AO_PWR_OFF_REQ, 32'h0);
    follow_sequence("peripheral up", 1, {CLK_BIT, ISO_BIT, RST_BIT, PWR_BIT});
    check_read("peripheral on PWR_STATUS", `AO_PWR_STATUS, 32'hF);
  endtask

  task automatic cpu_wakeup();
    write_reg("ext line enable", `AO_FAST_ENABLE, 32'h100);
    @(negedge clk);
    core_sleep = 1'b1;
    write_reg("cpu off request", `AO_PWR_OFF_REQ, 32'h1);
    wait_domain_off("cpu sleep", 0);
    check_read("cpu off PWR_STATUS", `AO_PWR_STATUS, 32'hE);
    @(negedge clk);
    ext_fast = 2'b01;
    @(negedge clk);
    ext_fast = 2'b00;
    wait_irq("ext line", 1'b1);
    poll_status("cpu wake", 4'hF);
    check_read("cpu off request kept", `AO_PWR_OFF_REQ, 32'h1);
    repeat (10) @(negedge clk);
    check_value("cpu held on", 32'hF, {28'd0, pwr_ctrl[0]});
    write_reg("ext pending clear", `AO_FAST_PENDING, 32'h100);
    check_value("irq_o after clear", 32'h0, {31'd0, irq});
    wait_domain_off("cpu sleep again", 0);
    @(negedge clk);
    core_sleep = 1'b0;
    write_reg("cpu on request", `AO_PWR_OFF_REQ, 32'h0);
    poll_status("cpu on", 4'hF);
  endtask

  task automatic map_edges();
    write_reg("bank retentive", `AO_BANK_RETENTIVE, 32'h2);
    check_read("bank retentive readback", `AO_BANK_RETENTIVE, 32'h2);
    check_value("bank_retentive_no", 32'h1, {30'd0, bank_ret_n});
    expect_error("block 3 read", 1'b0, 8'hC0);
    expect_error("block 3 write", 1'b1, 8'hC4);
    expect_error("power unknown offset", 1'b0, 8'h0C);
    expect_error("gpio unknown offset", 1'b0, 8'h54);
    expect_error("fast unknown offset", 1'b1, 8'h88);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    gpio_in    = '0;
    ext_fast   = '0;
    core_sleep = 1'b0;
    ack_n      = '1;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    rng        = 32'ha711_79e0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    #1;
    reset_state();
    gpio_registers();
    gpio_interrupts();
    peripheral_sequence();
    cpu_wakeup();
    map_edges();
    $display("tb_ao_subsystem: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
logic/ao_bus_pkg.sv
logic/ao_power_pkg.sv
logic/power_domain_seq.sv
logic/power_manager.sv
logic/gpio_ao.sv
logic/fast_intr_ctrl.sv
logic/ao_reg_demux.sv
logic/ao_subsystem.sv
test/tb_ao_subsystem.sv
